//--- mem_stage.f
common/lsu_pkg.sv
mem_stage/store_align.sv
mem_stage/load_extract.sv
mem_stage/lsu_ctrl_fsm.sv
source/bus_watchdog.sv
source/mem_model.sv
source/mem_stage_top.sv
verif/mem_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f mem_stage.f --top-module mem_stage_tb

out=$(./obj_dir/Vmem_stage_tb)
echo "$out"
echo "$out" | grep -qx "Result: PASSED"

//--- verif/mem_stage_tb.sv
// mem_stage_tb: directed tests of the data-memory stage against a reference memory
`timescale 1ns/100ps

module mem_stage_tb
  import lsu_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 32;
  localparam int MEM_WORDS      = 256;
  localparam int MEM_LATENCY    = 3;
  localparam int NUM_OPS        = 120;  // ops issued by all tests, rounded up
  localparam int MAX_CYCLES     = NUM_OPS * (TIMEOUT_CYCLES + 10);

  logic        clk;
  logic        rst_n_i;
  logic        op_valid_i;
  lsu_op_t     op_i;
  logic        op_ready_o;
  logic        done_o;
  lsu_result_t result_o;

  logic [XLEN-1:0] ref_mem [MEM_WORDS];  // mirrors every store
  lsu_result_t     res;
  int              errors;
  int              accept_cnt;
  int              done_cnt;
  int              cycle_cnt;

  mem_stage_top #(
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES),
    .MEM_WORDS     (MEM_WORDS),
    .MEM_LATENCY   (MEM_LATENCY)
  ) i_mem_stage_top (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .op_valid_i(op_valid_i),
    .op_i      (op_i),
    .op_ready_o(op_ready_o),
    .done_o    (done_o),
    .result_o  (result_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // handshake counts, sampled on the falling edge
  always @(negedge clk) begin
    if (rst_n_i) begin
      if (op_valid_i && op_ready_o) accept_cnt++;
      if (done_o) done_cnt++;
    end
  end

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  function automatic lsu_op_t make_op(logic [63:0] addr, logic [63:0] wdata,
                                      access_size_t size, logic is_store, logic sext);
    lsu_op_t op;
    op.addr     = addr;
    op.wdata    = wdata;
    op.size     = size;
    op.is_store = is_store;
    op.sext     = sext;
    return op;
  endfunction

  // bytes of the access, taken from the low end of wdata
  task automatic ref_store(input logic [63:0] addr, input logic [63:0] wdata,
                           input access_size_t size);
    int n;
    int off;
    int w;
    n   = 1 << int'(size);
    off = int'(addr[2:0]);
    w   = int'(addr >> 3);
    for (int k = 0; k < n; k++) begin
      ref_mem[w][8*(off+k) +: 8] = wdata[8*k +: 8];
    end
  endtask

  function automatic logic [63:0] expect_load(logic [63:0] word, logic [2:0] off,
                                              access_size_t size, logic sext);
    int          bits;
    logic [63:0] v;
    logic [63:0] keep;
    bits = 8 << int'(size);
    v    = word >> (8 * off);
    if (bits < 64) begin
      keep = (64'd1 << bits) - 64'd1;
      v    = v & keep;
      if (sext && v[bits-1]) v = v | ~keep;
    end
    return v;
  endfunction

  // hold the op until accepted, then wait for its done pulse
  task automatic issue_op(input lsu_op_t op);
    @(posedge clk);
    op_valid_i <= 1'b1;
    op_i       <= op;
    @(negedge clk);
    while (!op_ready_o) @(negedge clk);
    @(posedge clk);
    op_valid_i <= 1'b0;
    @(negedge clk);
    while (!done_o) @(negedge clk);
    res = result_o;
  endtask

  task automatic check_status(input logic mis, input logic err);
    check_value("result_o.misaligned", res.misaligned, mis);
    check_value("result_o.bus_err", res.bus_err, err);
  endtask

  task automatic store_tracked(input logic [63:0] addr, input logic [63:0] data,
                               input access_size_t size);
    issue_op(make_op(addr, data, size, 1'b1, 1'b0));
    check_status(1'b0, 1'b0);
    ref_store(addr, data, size);
  endtask

  task automatic load_checked(input logic [63:0] addr, input access_size_t size,
                              input logic sext, input logic [63:0] exp);
    issue_op(make_op(addr, 64'h0, size, 1'b0, sext));
    check_status(1'b0, 1'b0);
    check_value($sformatf("result_o.rdata @%h", addr), res.rdata, exp);
  endtask

  task automatic dword_roundtrip();
    logic [63:0] addr;
    logic [63:0] data;
    for (int i = 0; i < 4; i++) begin
      addr = 64'(($urandom % MEM_WORDS) * 8);
      data = {$urandom, $urandom};
      store_tracked(addr, data, SIZE_D);
      load_checked(addr, SIZE_D, 1'b0, data);
    end
  endtask

  task automatic store_lane_merge();
    logic [63:0] base;
    base = 64'h80;
    for (int s = 0; s < 3; s++) begin
      for (int off = 0; off < 8; off += (1 << s)) begin
        store_tracked(base + 64'(off), {$urandom, $urandom}, access_size_t'(s));
        load_checked(base, SIZE_D, 1'b0, ref_mem[int'(base >> 3)]);
      end
    end
  endtask

  // top bit of every byte set in one round and clear in the other
  task automatic load_extension();
    logic [63:0] base;
    logic [63:0] data;
    base = 64'hc0;
    for (int r = 0; r < 2; r++) begin
      data = {$urandom, $urandom};
      data = r ? (data & 64'h7f7f_7f7f_7f7f_7f7f) : (data | 64'h8080_8080_8080_8080);
      store_tracked(base, data, SIZE_D);
      for (int s = 0; s < 4; s++) begin
        for (int off = 0; off < 8; off += (1 << s)) begin
          for (int sx = 0; sx < 2; sx++) begin
            load_checked(base + 64'(off), access_size_t'(s), sx[0],
                         expect_load(data, 3'(off), access_size_t'(s), sx[0]));
          end
        end
      end
    end
  endtask

  task automatic misaligned_access();
    logic [63:0] base;
    base = 64'h100;
    store_tracked(base, {$urandom, $urandom}, SIZE_D);
    issue_op(make_op(base + 1, {$urandom, $urandom}, SIZE_H, 1'b1, 1'b0));
    check_status(1'b1, 1'b0);
    issue_op(make_op(base + 2, {$urandom, $urandom}, SIZE_W, 1'b1, 1'b0));
    check_status(1'b1, 1'b0);
    issue_op(make_op(base + 4, {$urandom, $urandom}, SIZE_D, 1'b1, 1'b0));
    check_status(1'b1, 1'b0);
    issue_op(make_op(base + 3, 64'h0, SIZE_H, 1'b0, 1'b1));
    check_status(1'b1, 1'b0);
    load_checked(base, SIZE_D, 1'b0, ref_mem[int'(base >> 3)]);  // memory untouched
  endtask

  task automatic unmapped_access();
    issue_op(make_op(64'(MEM_WORDS * 8) + 64'h10, 64'h0, SIZE_D, 1'b0, 1'b0));
    check_status(1'b0, 1'b1);
    check_value("result_o.rdata (unmapped)", res.rdata, 64'h0);
    issue_op(make_op(64'h8000_0000_0000_0080, 64'h0, SIZE_W, 1'b0, 1'b1));  // aliases word 16
    check_status(1'b0, 1'b1);
    check_value("result_o.rdata (unmapped)", res.rdata, 64'h0);
    load_checked(64'h80, SIZE_D, 1'b0, ref_mem[16]);
  endtask

  task automatic held_op_once();
    logic [63:0] base;
    logic [63:0] d0;
    logic [63:0] d1;
    int          acc0;
    int          done0;
    base = 64'h140;
    d0   = {$urandom, $urandom};
    d1   = {$urandom, $urandom};
    @(posedge clk);
    acc0       = accept_cnt;
    done0      = done_cnt;
    op_valid_i <= 1'b1;
    op_i       <= make_op(base, d0, SIZE_D, 1'b1, 1'b0);
    @(negedge clk);
    while (!op_ready_o) @(negedge clk);
    @(posedge clk);
    op_i <= make_op(base + 4, d1, SIZE_W, 1'b1, 1'b0);  // waits on the port while busy
    @(negedge clk);
    while (!op_ready_o) @(negedge clk);
    @(posedge clk);
    op_valid_i <= 1'b0;
    @(negedge clk);
    while (!done_o) @(negedge clk);
    @(posedge clk);
    check_value("accepted ops", 64'(accept_cnt - acc0), 64'd2);
    check_value("done_o pulses", 64'(done_cnt - done0), 64'd2);
    ref_store(base, d0, SIZE_D);
    ref_store(base + 4, d1, SIZE_W);
    load_checked(base, SIZE_D, 1'b0, ref_mem[int'(base >> 3)]);
  endtask

  initial begin
    errors     = 0;
    accept_cnt = 0;
    done_cnt   = 0;
    rst_n_i    = 1'b0;
    op_valid_i = 1'b0;
    op_i       = '0;
    void'($urandom(32'h62a6_7340));
    for (int w = 0; w < MEM_WORDS; w++) begin
      ref_mem[w] = '0;
    end
    repeat (10) @(posedge clk);
    rst_n_i <= 1'b1;
    dword_roundtrip();
    store_lane_merge();
    load_extension();
    misaligned_access();
    unmapped_access();
    held_op_once();
    repeat (2) @(posedge clk);
    check_value("done_o pulse count", 64'(done_cnt), 64'(accept_cnt));
    $display("errors: %0d, ops accepted: %0d, done pulses: %0d", errors, accept_cnt, done_cnt);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

endmodule

//--- source/mem_stage_top.sv
// mem_stage_top: data-memory access stage with its bus watchdog and memory model
`timescale 1ns/100ps

module mem_stage_top
  import lsu_pkg::*;
#(
  parameter int TIMEOUT_CYCLES = 32,
  parameter int MEM_WORDS      = 256,
  parameter int MEM_LATENCY    = 3
) (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        op_valid_i,
  input  lsu_op_t     op_i,
  output logic        op_ready_o,
  output logic        done_o,
  output lsu_result_t result_o
);

  logic     bus_req_valid;
  logic     bus_req_ready;
  bus_req_t bus_req;
  logic     bus_rsp_valid;
  logic     bus_rsp_ready;
  bus_rsp_t bus_rsp;
  logic     wd_start;
  logic     wd_active;
  logic     wd_expired;

  lsu_ctrl_fsm i_lsu_ctrl_fsm (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .op_valid_i     (op_valid_i),
    .op_i           (op_i),
    .op_ready_o     (op_ready_o),
    .bus_req_valid_o(bus_req_valid),
    .bus_req_o      (bus_req),
    .bus_req_ready_i(bus_req_ready),
    .bus_rsp_valid_i(bus_rsp_valid),
    .bus_rsp_i      (bus_rsp),
    .bus_rsp_ready_o(bus_rsp_ready),
    .wd_start_o     (wd_start),
    .wd_active_o    (wd_active),
    .wd_expired_i   (wd_expired),
    .done_o         (done_o),
    .result_o       (result_o)
  );

  bus_watchdog #(
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) i_bus_watchdog (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .start_i  (wd_start),
    .active_i (wd_active),
    .expired_o(wd_expired)
  );

  mem_model #(
    .MEM_WORDS  (MEM_WORDS),
    .MEM_LATENCY(MEM_LATENCY)
  ) i_mem_model (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .req_valid_i(bus_req_valid),
    .req_i      (bus_req),
    .req_ready_o(bus_req_ready),
    .rsp_valid_o(bus_rsp_valid),
    .rsp_o      (bus_rsp),
    .rsp_ready_i(bus_rsp_ready)
  );

endmodule

//--- source/mem_model.sv
// mem_model: data memory slave with fixed response latency over a mapped range
`timescale 1ns/100ps

module mem_model
  import lsu_pkg::*;
#(
  parameter int MEM_WORDS   = 256,
  parameter int MEM_LATENCY = 3
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     req_valid_i,
  input  bus_req_t req_i,
  output logic     req_ready_o,
  output logic     rsp_valid_o,
  output bus_rsp_t rsp_o,
  input  logic     rsp_ready_i
);

  localparam int AW = $clog2(MEM_WORDS);
  localparam int LW = $clog2(MEM_LATENCY + 1);

  logic [XLEN-1:0] mem [MEM_WORDS];
  logic [AW-1:0]   idx;
  logic            mapped;
  logic            req_fire;
  logic            pending;
  logic [LW-1:0]   lat_cnt;
  logic [XLEN-1:0] rdata_q;

  assign idx      = req_i.addr[3 +: AW];
  assign mapped   = (req_i.addr[XLEN-1:3] < (XLEN-3)'(MEM_WORDS));
  assign req_fire = req_valid_i && req_ready_o;
  assign rsp_o    = '{rdata: rdata_q, err: 1'b0};  // failure shows only as silence

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      req_ready_o <= 1'b0;
      rsp_valid_o <= 1'b0;
      pending     <= 1'b0;
      lat_cnt     <= '0;
    end else begin
      req_ready_o <= req_valid_i && !req_ready_o && !pending && !rsp_valid_o;
      if (req_fire && mapped) begin
        if (MEM_LATENCY <= 1) begin
          rsp_valid_o <= 1'b1;
        end else begin
          pending <= 1'b1;
          lat_cnt <= LW'(MEM_LATENCY - 1);
        end
      end else if (pending) begin
        if (lat_cnt == LW'(1)) begin
          pending     <= 1'b0;
          rsp_valid_o <= 1'b1;
        end else begin
          lat_cnt <= lat_cnt - 1'b1;
        end
      end
      if (rsp_valid_o && rsp_ready_i) rsp_valid_o <= 1'b0;
    end
  end

  // read returns the word as it was before a write
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int w = 0; w < MEM_WORDS; w++) mem[w] <= '0;
    end else if (req_fire && mapped && req_i.we) begin
      for (int b = 0; b < LANES; b++) begin
        if (req_i.wmask[b]) mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire && mapped) rdata_q <= mem[idx];
  end

endmodule

//--- source/bus_watchdog.sv
// bus_watchdog: flags a bus response that has not come within a cycle limit
`timescale 1ns/100ps

module bus_watchdog #(
  parameter int TIMEOUT_CYCLES = 32
) (
  input  logic clk,
  input  logic rst_n_i,
  input  logic start_i,
  input  logic active_i,
  output logic expired_o
);

  localparam int CW = $clog2(TIMEOUT_CYCLES + 1);

  logic [CW-1:0] cnt;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      cnt       <= '0;
      expired_o <= 1'b0;
    end else begin
      expired_o <= 1'b0;
      if (start_i) begin
        cnt <= '0;
      end else if (active_i && cnt != CW'(TIMEOUT_CYCLES)) begin
        cnt       <= cnt + 1'b1;  // sticks at the limit, so one pulse only
        expired_o <= (cnt == CW'(TIMEOUT_CYCLES - 1));
      end
    end
  end

  // the waiting side must still be waiting when the pulse lands
  a_expired_active: assert property (@(posedge clk) disable iff (!rst_n_i)
    expired_o |-> active_i);

endmodule

//--- mem_stage/lsu_ctrl_fsm.sv
// lsu_ctrl_fsm: sequences one access through bus request, response and completion
`timescale 1ns/100ps

module lsu_ctrl_fsm
  import lsu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        op_valid_i,
  input  lsu_op_t     op_i,
  output logic        op_ready_o,
  output logic        bus_req_valid_o,
  output bus_req_t    bus_req_o,
  input  logic        bus_req_ready_i,
  input  logic        bus_rsp_valid_i,
  input  bus_rsp_t    bus_rsp_i,
  output logic        bus_rsp_ready_o,
  output logic        wd_start_o,
  output logic        wd_active_o,
  input  logic        wd_expired_i,
  output logic        done_o,
  output lsu_result_t result_o
);

  typedef enum logic [1:0] {IDLE, REQ, RSP, DONE} state_t;

  state_t       state;
  bus_req_t     aligned_req;
  logic         misaligned;
  logic         accept;
  logic [2:0]   offset_q;
  access_size_t size_q;
  logic         sext_q;
  bus_req_t     req_q;
  logic [XLEN-1:0] load_value;

  store_align i_store_align (
    .op_i        (op_i),
    .req_o       (aligned_req),
    .misaligned_o(misaligned)
  );

  load_extract i_load_extract (
    .offset_i(offset_q),
    .size_i  (size_q),
    .sext_i  (sext_q),
    .rdata_i (bus_rsp_i.rdata),
    .value_o (load_value)
  );

  assign op_ready_o      = (state == IDLE);
  assign accept          = op_valid_i && op_ready_o;
  assign bus_req_valid_o = (state == REQ);
  assign bus_req_o       = req_q;
  assign bus_rsp_ready_o = (state == RSP);
  assign wd_start_o      = bus_req_valid_o && bus_req_ready_i;  // timer starts at issue
  assign wd_active_o     = (state == RSP);
  assign done_o          = (state == DONE);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state    <= IDLE;
      result_o <= '0;
    end else begin
      case (state)
        IDLE: if (accept) begin
          if (misaligned) begin
            state    <= DONE;  // never reaches the bus
            result_o <= '{rdata: '0, misaligned: 1'b1, bus_err: 1'b0};
          end else begin
            state <= REQ;
          end
        end
        REQ: if (bus_req_ready_i) state <= RSP;
        RSP: begin
          if (bus_rsp_valid_i) begin
            state    <= DONE;
            result_o <= '{rdata: req_q.we ? '0 : load_value, misaligned: 1'b0,
                          bus_err: bus_rsp_i.err};
          end else if (wd_expired_i) begin
            state    <= DONE;  // abort, no answer
            result_o <= '{rdata: '0, misaligned: 1'b0, bus_err: 1'b1};
          end
        end
        default: state <= IDLE;  // DONE lasts one cycle
      endcase
    end
  end

  // captured access, held while the bus works on it
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q    <= aligned_req;
      offset_q <= op_i.addr[2:0];
      size_q   <= op_i.size;
      sext_q   <= op_i.sext;
    end
  end

  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    bus_req_valid_o && !bus_req_ready_i |=> bus_req_valid_o && $stable(bus_req_o));

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
    done_o |=> !done_o);

endmodule

//--- mem_stage/load_extract.sv
// load_extract: picks the loaded bytes out of the bus word and extends them to 64 bits
`timescale 1ns/100ps

module load_extract
  import lsu_pkg::*;
(
  input  logic [2:0]      offset_i,
  input  access_size_t    size_i,
  input  logic            sext_i,
  input  bus_word_u       rdata_i,
  output logic [XLEN-1:0] value_o
);

  bus_word_u shifted;
  logic      fill;

  // move the addressed lane down to lane 0
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      if (i + int'(offset_i) < LANES) begin
        shifted.lane[i] = rdata_i.lane[3'(i + int'(offset_i))];
      end else begin
        shifted.lane[i] = 8'h00;
      end
    end
  end

  // top kept bit, or zero when unsigned
  always_comb begin
    case (size_i)
      SIZE_B:  fill = sext_i & shifted.lane[0][7];
      SIZE_H:  fill = sext_i & shifted.lane[1][7];
      SIZE_W:  fill = sext_i & shifted.lane[3][7];
      default: fill = 1'b0;  // full width, nothing to fill
    endcase
  end

  always_comb begin
    case (size_i)
      SIZE_B: begin
        value_o = {{56{fill}}, shifted.lane[0]};
      end
      SIZE_H: begin
        value_o = {{48{fill}}, shifted.lane[1], shifted.lane[0]};
      end
      SIZE_W: begin
        value_o = {{32{fill}}, shifted.dword[31:0]};
      end
      default: begin
        value_o = shifted.dword;
      end
    endcase
  end

endmodule

//--- mem_stage/store_align.sv
// store_align: alignment check and byte-lane placement of store data and mask
`timescale 1ns/100ps

module store_align
  import lsu_pkg::*;
(
  input  lsu_op_t  op_i,
  output bus_req_t req_o,
  output logic     misaligned_o
);

  logic [2:0] offset;
  logic [7:0] size_mask;
  bus_word_u  src;
  bus_word_u  placed;

  assign offset  = op_i.addr[2:0];
  assign src.dword = op_i.wdata;

  always_comb begin
    case (op_i.size)
      SIZE_B: begin
        size_mask    = 8'h01;
        misaligned_o = 1'b0;
      end
      SIZE_H: begin
        size_mask    = 8'h03;
        misaligned_o = offset[0];
      end
      SIZE_W: begin
        size_mask    = 8'h0f;
        misaligned_o = |offset[1:0];
      end
      default: begin
        size_mask    = 8'hff;
        misaligned_o = |offset;
      end
    endcase
  end

  // lane i takes source byte i - offset
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      placed.lane[i] = (i >= int'(offset)) ? src.lane[3'(i - int'(offset))] : 8'h00;
    end
  end

  assign req_o.addr  = {op_i.addr[XLEN-1:3], 3'b000};
  assign req_o.wdata = placed.dword;
  assign req_o.wmask = op_i.is_store ? (size_mask << offset) : '0;  // loads write nothing
  assign req_o.we    = op_i.is_store;

  always_comb begin
    if (op_i.is_store && !misaligned_o) begin
      a_store_mask: assert (req_o.wmask != '0);
    end
  end

endmodule

//--- common/lsu_pkg.sv
// lsu_pkg shares widths, access sizes and bus records across the data-memory stage
package lsu_pkg;

  localparam int XLEN = 64;
  localparam int LANES = XLEN / 8;

  // access width in bytes is 1 << size
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } access_size_t;

  // one load or store from the pipeline
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;  // rs2 with the low bytes significant
    access_size_t    size;
    logic            is_store;
    logic            sext;
  } lsu_op_t;

  typedef struct packed {
    logic [XLEN-1:0]  addr;   // doubleword aligned
    logic [XLEN-1:0]  wdata;
    logic [LANES-1:0] wmask;  // one bit per byte lane
    logic             we;
  } bus_req_t;

  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            err;
  } bus_rsp_t;

  // bus word seen whole or as byte lanes
  typedef union packed {
    logic [XLEN-1:0]          dword;
    logic [LANES-1:0][7:0]    lane;
  } bus_word_u;

  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            misaligned;
    logic            bus_err;
  } lsu_result_t;

endpackage
